//--- hdl/iso_pkg.sv
// ==========================================================
// Isochronous frame link shared types
// Widths of the sample word, the frame number and the frame
// sum, plus the tagged word and the per-frame summary that
// travel between the blocks of the link
// ==========================================================

`default_nettype none

package iso_pkg;

  // One sample word as delivered by the outside source
  localparam int unsigned DATA_W = 16;

  // Frame numbers wrap modulo 16
  localparam int unsigned FRAME_ID_W = 4;

  // Room for 256 words of 16 bits without overflow
  localparam int unsigned SUM_W = 24;

  // Word count per frame, enough for the largest frame length
  localparam int unsigned COUNT_W = 8;

  // Tagged word as it crosses from the source to the destination domain
  // The last flag marks the final word of a frame
  typedef struct packed {
    logic [FRAME_ID_W-1:0] frame_id;
    logic                  last;
    logic [DATA_W-1:0]     data;
  } iso_word_t;

  // Summary issued once per frame by the checker
  // The sum is the modular sum of all data fields of the frame
  typedef struct packed {
    logic [FRAME_ID_W-1:0] frame_id;
    logic [COUNT_W-1:0]    count;
    logic [SUM_W-1:0]      sum;
  } frame_sum_t;

endpackage

`default_nettype wire

//--- hdl/iso_spill_register.sv
// ==========================================================
// Isochronous spill register
// Two-entry dual-clock FIFO between two derived clocks with
// a fixed phase relation. The write pointer lives in the
// source domain and the read pointer in the destination
// domain. Static timing covers the crossing paths, so there
// are no synchronizers
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module iso_spill_register (
  input  wire logic              src_clk_i,
  input  wire logic              dst_clk_i,
  input  wire logic              arst_n_i,
  // Source side handshake
  input  wire logic              src_valid_i,
  output logic                   src_ready_o,
  input  iso_pkg::iso_word_t     src_word_i,
  // Destination side handshake
  output logic                   dst_valid_o,
  input  wire logic              dst_ready_i,
  output iso_pkg::iso_word_t     dst_word_o
);

  import iso_pkg::*;

  // Both pointers carry one extra bit above the entry select
  // Equal pointers mean empty and a difference in the top bit only means full
  logic [1:0] wr_ptr_q;
  logic [1:0] rd_ptr_q;
  logic [1:0] ptr_diff;

  logic push;
  logic pop;

  // The two storage entries are only ever written from the source side
  iso_word_t mem_q [2];

  assign ptr_diff = wr_ptr_q ^ rd_ptr_q;

  // Full when the low bits agree and the top bits differ
  assign src_ready_o = (ptr_diff != 2'b10);

  // Anything but equal pointers leaves at least one word to read
  assign dst_valid_o = (ptr_diff != 2'b00);

  assign push = src_valid_i & src_ready_o;
  assign pop  = dst_valid_o & dst_ready_i;

  // Write pointer advances on a source-side transfer
  always_ff @(posedge src_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= 2'b00;
    end else if (push) begin
      wr_ptr_q <= wr_ptr_q + 2'd1;
    end
  end

  // The entry under the write pointer takes the incoming word
  always_ff @(posedge src_clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q[0]] <= src_word_i;
    end
  end

  // Read pointer advances when the destination takes a word
  always_ff @(posedge dst_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q <= 2'b00;
    end else if (pop) begin
      rd_ptr_q <= rd_ptr_q + 2'd1;
    end
  end

  // Output data comes straight from the entry the read pointer selects
  assign dst_word_o = mem_q[rd_ptr_q[0]];

endmodule

`default_nettype wire

//--- hdl/frame_tagger.sv
// ==========================================================
// Frame tagger
// Source-domain stage that groups incoming sample words into
// frames of FrameLen words. Each word leaves with its frame
// number and a flag on the last word of the frame. The
// handshake passes through with zero latency
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module frame_tagger #(
  // Words per frame, from 1 to 255
  parameter int unsigned FrameLen = 8
) (
  input  wire logic                      src_clk_i,
  input  wire logic                      arst_n_i,
  // Raw words from the outside source
  input  wire logic                      in_valid_i,
  output logic                           in_ready_o,
  input  wire logic [iso_pkg::DATA_W-1:0] in_data_i,
  // Tagged words towards the spill register
  output logic                           out_valid_o,
  input  wire logic                      out_ready_i,
  output iso_pkg::iso_word_t             out_word_o
);

  import iso_pkg::*;

  // Index of the final word inside a frame
  localparam logic [COUNT_W-1:0] LastIdx = COUNT_W'(FrameLen - 1);

  logic [COUNT_W-1:0]    word_idx_q;
  logic [FRAME_ID_W-1:0] frame_id_q;
  logic                  is_last;
  logic                  xfer;

  // The tagger never stalls on its own, it only forwards back-pressure
  assign out_valid_o = in_valid_i;
  assign in_ready_o  = out_ready_i;

  assign xfer    = in_valid_i & out_ready_i;
  assign is_last = (word_idx_q == LastIdx);

  // Word formed from the counters as they stand before the transfer
  always_comb begin
    out_word_o          = '0;
    out_word_o.frame_id = frame_id_q;
    out_word_o.last     = is_last;
    out_word_o.data     = in_data_i;
  end

  // Word index wraps after the last word of a frame
  // The frame number steps at the same edge and wraps modulo 16
  always_ff @(posedge src_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      word_idx_q <= '0;
      frame_id_q <= '0;
    end else if (xfer) begin
      if (is_last) begin
        word_idx_q <= '0;
        frame_id_q <= frame_id_q + 1'b1;
      end else begin
        word_idx_q <= word_idx_q + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/frame_checker.sv
// ==========================================================
// Frame checker
// Destination-domain stage that sums the data of each frame
// and counts its words. On the last word of a frame it loads
// a summary and pulses frame_done_o for one cycle. Back-
// pressure comes only from the dst_hold_i input
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module frame_checker (
  input  wire logic          dst_clk_i,
  input  wire logic          arst_n_i,
  // Tagged words from the spill register
  input  wire logic          in_valid_i,
  output logic               in_ready_o,
  input  iso_pkg::iso_word_t in_word_i,
  // Stall request from the destination
  input  wire logic          dst_hold_i,
  // Per-frame summary strobe and its payload
  output logic               frame_done_o,
  output iso_pkg::frame_sum_t frame_sum_o
);

  import iso_pkg::*;

  // Accumulators for the frame in progress
  logic [SUM_W-1:0]   sum_q;
  logic [COUNT_W-1:0] count_q;

  // Values including the word on the input this cycle
  logic [SUM_W-1:0]   sum_next;
  logic [COUNT_W-1:0] count_next;

  logic       xfer;
  logic       done_q;
  frame_sum_t summary_q;

  // The checker takes a word every cycle unless the destination holds it off
  assign in_ready_o = ~dst_hold_i;
  assign xfer       = in_valid_i & in_ready_o;

  // Data is zero-extended, the sum wraps at its own width
  assign sum_next   = sum_q + SUM_W'(in_word_i.data);
  assign count_next = count_q + 1'b1;

  // Running sum and word count
  // Both clear after the last word so the next frame starts from zero
  always_ff @(posedge dst_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sum_q   <= '0;
      count_q <= '0;
    end else if (xfer) begin
      if (in_word_i.last) begin
        sum_q   <= '0;
        count_q <= '0;
      end else begin
        sum_q   <= sum_next;
        count_q <= count_next;
      end
    end
  end

  // The done strobe is high for exactly one cycle after a last word
  always_ff @(posedge dst_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      done_q <= 1'b0;
    end else begin
      done_q <= xfer & in_word_i.last;
    end
  end

  // Summary register loads with the closing word folded in
  // It keeps its value until the next frame completes
  always_ff @(posedge dst_clk_i) begin
    if (xfer && in_word_i.last) begin
      summary_q.frame_id <= in_word_i.frame_id;
      summary_q.count    <= count_next;
      summary_q.sum      <= sum_next;
    end
  end

  assign frame_done_o = done_q;
  assign frame_sum_o  = summary_q;

endmodule

`default_nettype wire

//--- hdl/iso_frame_link.sv
// ==========================================================
// Isochronous frame link
// Carries 16-bit sample words from the source clock domain,
// running at twice the destination rate, into the
// destination domain. Words are tagged into frames, cross
// through a two-entry spill register and are summed per
// frame on the far side
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module iso_frame_link #(
  // Words per frame, passed down to the tagger
  parameter int unsigned FrameLen = 8
) (
  input  wire logic                      src_clk_i,
  input  wire logic                      dst_clk_i,
  input  wire logic                      arst_n_i,
  // Source domain stream
  input  wire logic                      src_valid_i,
  output logic                           src_ready_o,
  input  wire logic [iso_pkg::DATA_W-1:0] src_data_i,
  // Destination domain control and results
  input  wire logic                      dst_hold_i,
  output logic                           frame_done_o,
  output iso_pkg::frame_sum_t            frame_sum_o
);

  import iso_pkg::*;

  // Tagged stream between tagger and spill register, source domain
  logic      tag_valid;
  logic      tag_ready;
  iso_word_t tag_word;

  // Stream leaving the spill register, destination domain
  logic      xing_valid;
  logic      xing_ready;
  iso_word_t xing_word;

  // Numbers frames and flags the last word, all on src_clk_i
  frame_tagger #(
    .FrameLen (FrameLen)
  ) u_frame_tagger (
    .src_clk_i   (src_clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (src_valid_i),
    .in_ready_o  (src_ready_o),
    .in_data_i   (src_data_i),
    .out_valid_o (tag_valid),
    .out_ready_i (tag_ready),
    .out_word_o  (tag_word)
  );

  // The clock crossing itself
  // Source ready drops once both entries are occupied
  iso_spill_register u_iso_spill_register (
    .src_clk_i   (src_clk_i),
    .dst_clk_i   (dst_clk_i),
    .arst_n_i    (arst_n_i),
    .src_valid_i (tag_valid),
    .src_ready_o (tag_ready),
    .src_word_i  (tag_word),
    .dst_valid_o (xing_valid),
    .dst_ready_i (xing_ready),
    .dst_word_o  (xing_word)
  );

  // Accumulates each frame and strobes one summary per frame on dst_clk_i
  frame_checker u_frame_checker (
    .dst_clk_i    (dst_clk_i),
    .arst_n_i     (arst_n_i),
    .in_valid_i   (xing_valid),
    .in_ready_o   (xing_ready),
    .in_word_i    (xing_word),
    .dst_hold_i   (dst_hold_i),
    .frame_done_o (frame_done_o),
    .frame_sum_o  (frame_sum_o)
  );

endmodule

`default_nettype wire

//--- tests/tb_iso_frame_link.sv
// ==========================================================
// Testbench for the isochronous frame link
// Drives random words on the 2x source clock, random hold
// bursts on the destination side, and checks every frame
// summary against sums kept from the accepted words
// ==========================================================

`timescale 1ns/1ps
`default_nettype none

module tb_iso_frame_link;

  import iso_pkg::*;

  localparam int unsigned FrameLen  = 8;
  localparam int unsigned NumFrames = 40;
  localparam int unsigned NumWords  = FrameLen * NumFrames;

  // 320 words take roughly one destination cycle each when not held
  // Hold bursts can stretch that to a few times over, 6000 leaves wide margin
  localparam int unsigned TimeoutCycles = 6000;

  localparam logic [31:0] Seed = 32'h3192_30a5;

  logic                src_clk_i;
  logic                dst_clk_i;
  logic                arst_n_i;
  logic                src_valid_i;
  logic                src_ready_o;
  logic [DATA_W-1:0]   src_data_i;
  logic                dst_hold_i;
  logic                frame_done_o;
  frame_sum_t          frame_sum_o;

  // Every word the link has taken on the source side, in order
  logic [DATA_W-1:0]   accepted_words[$];

  // Index of the first word of the next frame still to be summed
  int unsigned         check_idx = 0;
  int unsigned         frames_checked = 0;
  logic [FRAME_ID_W-1:0] exp_frame_id = '0;
  logic                done_prev = 1'b0;

  // Transfer seen at the most recent source edge for the driver to read
  logic                src_xfer_seen = 1'b0;
  // Source transfers since the destination started holding
  int unsigned         held_pushes = 0;
  int unsigned         idle_cycles = 0;
  int unsigned         cycle_count = 0;

  logic [31:0]         src_rand;
  logic [31:0]         hold_rand;

  iso_frame_link #(
    .FrameLen (FrameLen)
  ) u_iso_frame_link (
    .src_clk_i    (src_clk_i),
    .dst_clk_i    (dst_clk_i),
    .arst_n_i     (arst_n_i),
    .src_valid_i  (src_valid_i),
    .src_ready_o  (src_ready_o),
    .src_data_i   (src_data_i),
    .dst_hold_i   (dst_hold_i),
    .frame_done_o (frame_done_o),
    .frame_sum_o  (frame_sum_o)
  );

  // Destination clock rises at 50 ns and every 100 ns after
  initial begin
    dst_clk_i = 1'b0;
    forever #50 dst_clk_i = ~dst_clk_i;
  end

  // Source clock runs at twice the rate, so each dst rising edge is also a src one
  initial begin
    src_clk_i = 1'b1;
    forever #25 src_clk_i = ~src_clk_i;
  end

  // Plain 32-bit LCG
  function automatic logic [31:0] next_random(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic halt_with_error(input string msg);
    $display("[ERROR] time %0d ns: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "check failed");
  endtask

  // Reset, then random words with random gaps until all frames are sent
  initial begin : drive_source
    arst_n_i    <= 1'b0;
    src_valid_i <= 1'b0;
    src_data_i  <= '0;
    src_rand    = Seed;
    repeat (16) @(posedge dst_clk_i);
    @(negedge src_clk_i);
    arst_n_i <= 1'b1;
    // Quiet period so the idle state after reset can be observed
    repeat (8) @(negedge src_clk_i);
    while (accepted_words.size() < NumWords) begin
      // A word already offered stays put until it is taken
      if (!src_valid_i || src_xfer_seen) begin
        src_rand = next_random(src_rand);
        src_valid_i <= (src_rand[15:12] > 4'd3);
        src_data_i  <= src_rand[31:16];
      end
      @(negedge src_clk_i);
    end
    src_valid_i <= 1'b0;
    wait (frames_checked == NumFrames);
    // A stray extra summary in these cycles finds no words left to cover it
    repeat (4) @(negedge dst_clk_i);
    $display("TEST PASSED");
    $finish;
  end

  // Hold bursts of 2 to 17 destination cycles start at random
  initial begin : drive_hold
    int unsigned hold_left;
    dst_hold_i <= 1'b0;
    hold_rand  = ~Seed;
    hold_left  = 0;
    wait (arst_n_i);
    while (frames_checked < NumFrames) begin
      @(negedge dst_clk_i);
      hold_rand = next_random(hold_rand);
      if (hold_left != 0) begin
        hold_left--;
        if (hold_left == 0) begin
          dst_hold_i <= 1'b0;
        end
      end else if (hold_rand[15:13] == 3'd0) begin
        dst_hold_i <= 1'b1;
        hold_left  = 2 + hold_rand[27:24];
      end
    end
    dst_hold_i <= 1'b0;
  end

  // Source side transfers, and the limit on words taken while the far side holds
  always @(posedge src_clk_i) begin : watch_source
    src_xfer_seen = 1'b0;
    if (arst_n_i) begin
      if (dst_hold_i) begin
        // Two words taken under hold fill both entries
        if (held_pushes >= 2) begin
          assert (!src_ready_o)
            else halt_with_error("src_ready_o high with both entries filled under hold");
        end
      end else begin
        held_pushes = 0;
      end
      if (src_valid_i && src_ready_o) begin
        accepted_words.push_back(src_data_i);
        src_xfer_seen = 1'b1;
        if (dst_hold_i) begin
          held_pushes++;
        end
        assert (held_pushes <= 2)
          else halt_with_error($sformatf("%0d words accepted under hold", held_pushes));
      end
    end
  end

  // Reset values are checked mid-cycle on the source clock
  always @(negedge src_clk_i) begin : check_reset_state
    if (!arst_n_i || idle_cycles < 6) begin
      assert (!frame_done_o)
        else halt_with_error("frame_done_o high during or just after reset");
      assert (src_ready_o)
        else halt_with_error("src_ready_o low during or just after reset");
    end
    if (arst_n_i && idle_cycles < 6) begin
      idle_cycles++;
    end
  end

  // Each summary must cover exactly the next FrameLen accepted words
  always @(negedge dst_clk_i) begin : check_summary
    logic [SUM_W-1:0] exp_sum;
    int unsigned      idx;
    if (arst_n_i) begin
      if (FrameLen > 1) begin
        assert (!(frame_done_o && done_prev))
          else halt_with_error("frame_done_o high for two destination cycles in a row");
      end
      if (frame_done_o) begin
        assert (accepted_words.size() >= check_idx + FrameLen)
          else halt_with_error($sformatf("summary %0d arrived with only %0d words accepted",
                                         frames_checked, accepted_words.size()));
        exp_sum = '0;
        for (idx = 0; idx < FrameLen; idx++) begin
          exp_sum = exp_sum + SUM_W'(accepted_words[check_idx + idx]);
        end
        assert (frame_sum_o.sum == exp_sum)
          else halt_with_error($sformatf("frame %0d sum is %h, expected %h",
                                         frames_checked, frame_sum_o.sum, exp_sum));
        assert (frame_sum_o.count == COUNT_W'(FrameLen))
          else halt_with_error($sformatf("frame %0d count is %0d, expected %0d",
                                         frames_checked, frame_sum_o.count, FrameLen));
        assert (frame_sum_o.frame_id == exp_frame_id)
          else halt_with_error($sformatf("frame %0d id is %0d, expected %0d",
                                         frames_checked, frame_sum_o.frame_id, exp_frame_id));
        check_idx    = check_idx + FrameLen;
        exp_frame_id = exp_frame_id + 1'b1;
        frames_checked++;
      end
      done_prev = frame_done_o;
    end
  end

  // Run limit in destination cycles
  always @(posedge dst_clk_i) begin : watch_timeout
    cycle_count++;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout after %0d destination cycles, %0d of %0d frames checked",
               cycle_count, frames_checked, NumFrames);
      $display("TEST FAILED");
      $fatal(1, "simulation timeout");
    end
  end

endmodule

`default_nettype wire

//--- tb.f
hdl/iso_pkg.sv
hdl/iso_spill_register.sv
hdl/frame_tagger.sv
hdl/frame_checker.sv
hdl/iso_frame_link.sv
tests/tb_iso_frame_link.sv

//--- Makefile
# Verilator build and run of the isochronous frame link testbench

TOP := tb_iso_frame_link

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f tb.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
